// File: source/topBroadcastPkg.sv
`default_nettype none

package topBroadcastPkg;

    // One configuration word as broadcast to every receiver
    parameter int TOP_WIDTH = 128;

    // Two index steps per bit, plus the done bit on top
    parameter int INDEX_WIDTH = $clog2(2 * TOP_WIDTH) + 1;

    parameter int CHANNEL_WIDTH = 2; // Data wire above, control wire below

    // Manager states
    // IDLE waits for a new top and keeps stall low
    // PENDING holds the top and restarts the transmitter every cycle
    // SENDING lets the last transmission run out and waits for done
    typedef enum logic [1:0] {
        IDLE,
        PENDING,
        SENDING
    } managerState_t;

endpackage

`default_nettype wire

// File: source/warmupTimer.sv
`timescale 1ns/1ps
`default_nettype none

module warmupTimer #(
    parameter int WARMUP_CYCLES = 15
) (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    output logic warmingUp
);

    localparam int COUNT_WIDTH = $clog2(WARMUP_CYCLES + 1);
    localparam logic [COUNT_WIDTH-1:0] COUNT_LIMIT = COUNT_WIDTH'(WARMUP_CYCLES);

    logic [COUNT_WIDTH-1:0] count;

    // Reset parks the counter at its limit, so nothing is warming up until the first top
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= COUNT_LIMIT;
        end else if (restart) begin
            count <= '0;
        end else if (count != COUNT_LIMIT) begin
            count <= count + 1'b1;
        end
    end

    // Gives pipelineIsEmpty time to settle after a new top is taken
    assign warmingUp = (count != COUNT_LIMIT);

    // Once saturated the counter stays at its limit until the next restart
    assert property (@(posedge clk) disable iff (rst)
        (count == COUNT_LIMIT && !restart) |=> count == COUNT_LIMIT)
        else $error("warmup counter ran past its limit");

endmodule

`default_nettype wire

// File: source/topManager.sv
`timescale 1ns/1ps
`default_nettype none

module topManager (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [topBroadcastPkg::TOP_WIDTH-1:0] topIn,
    input  logic                                topInValid,
    input  logic                                pipelineIsEmpty,
    input  logic                                warmingUp,
    input  logic                                doneTransmitting,
    output logic                                stallInput,
    output logic                                restart,
    output logic                                transmitTop,
    output logic [topBroadcastPkg::TOP_WIDTH-1:0] pendingTop
);

    import topBroadcastPkg::*;

    managerState_t state;
    logic          holdOff;

    // The restart term covers the first PENDING cycle, before the timer has seen the strobe
    assign holdOff = !pipelineIsEmpty || warmingUp || restart;

    assign stallInput = (state != IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            restart <= 1'b0;
        end else begin
            restart <= topInValid; // One cycle behind the strobe
        end
    end

    // Captured on the strobe and held until the next top is accepted
    always_ff @(posedge clk) begin
        if (state == IDLE && topInValid) begin
            pendingTop <= topIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            transmitTop <= 1'b0;
        end else begin
            transmitTop <= 1'b0;
            case (state)
                IDLE: begin
                    if (topInValid) begin
                        state <= PENDING;
                    end
                end
                PENDING: begin
                    if (holdOff) begin
                        transmitTop <= 1'b1; // Start over from bit 0 next cycle
                    end else begin
                        state <= SENDING; // The last restart stands
                    end
                end
                SENDING: begin
                    if (doneTransmitting) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(topInValid && stallInput))
        else $error("new top offered while the manager is stalled");

    assert property (@(posedge clk) disable iff (rst) (state == IDLE) |-> !transmitTop)
        else $error("transmit pulse seen while idle");

    // The warmup has to outlast the done delay line, or a stale done would end SENDING early
    assert property (@(posedge clk) disable iff (rst)
        (state == PENDING && !holdOff) |-> !doneTransmitting)
        else $error("done still high from an earlier transmission when sending starts");

endmodule

`default_nettype wire

// File: source/topTransmitter.sv
`timescale 1ns/1ps
`default_nettype none

module topTransmitter #(
    parameter int DONE_DELAY = 12
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [topBroadcastPkg::TOP_WIDTH-1:0]     pendingTop,
    input  logic                                    transmitTop,
    output logic                                    doneTransmitting,
    output logic [topBroadcastPkg::CHANNEL_WIDTH-1:0] topChannel
);

    import topBroadcastPkg::*;

    localparam logic [INDEX_WIDTH-1:0] INDEX_DONE = {1'b1, {(INDEX_WIDTH-1){1'b0}}};

    logic [INDEX_WIDTH-1:0] index;
    logic [INDEX_WIDTH-3:0] bitSelect;
    logic                   indexDone;
    logic                   dataBit;
    logic                   control;
    logic [DONE_DELAY-1:0]  doneDelay;

    assign indexDone = index[INDEX_WIDTH-1];
    assign bitSelect = index[INDEX_WIDTH-2:1]; // Each bit spans two index steps

    // Half-bit step counter, restarted by every transmit pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            index <= INDEX_DONE;
        end else if (transmitTop) begin
            index <= '0;
        end else if (!indexDone) begin
            index <= index + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dataBit <= 1'b0;
            control <= 1'b0;
        end else begin
            if (!indexDone) begin
                dataBit <= pendingTop[bitSelect]; // Holds the last bit once finished
            end
            // Toggling on the odd step puts the edge mid-bit for the receivers
            if (index[0]) begin
                control <= !control;
            end
        end
    end

    assign topChannel = {dataBit, control};

    // Long delay on done so that every receiver has taken the new top before stall drops
    always_ff @(posedge clk) begin
        if (rst) begin
            doneDelay <= '0;
        end else begin
            doneDelay <= {doneDelay[DONE_DELAY-2:0], indexDone};
        end
    end

    assign doneTransmitting = doneDelay[DONE_DELAY-1];

    assert property (@(posedge clk) disable iff (rst) indexDone |=> $stable(control))
        else $error("control wire toggled after the last bit");

endmodule

`default_nettype wire

// File: source/topReceiver.sv
`timescale 1ns/1ps
`default_nettype none

module topReceiver (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [topBroadcastPkg::CHANNEL_WIDTH-1:0] topChannel,
    output logic [topBroadcastPkg::TOP_WIDTH-1:0]     receivedTop
);

    import topBroadcastPkg::*;

    logic data;
    logic control;
    logic prevControl;
    logic toggled;
    logic toggledDelayed;
    logic dataSampled;
    logic dataDelayed;

    assign {data, control} = topChannel;

    // Both wires go through two registers, as a receiver in another clock domain would need
    always_ff @(posedge clk) begin
        if (rst) begin
            prevControl    <= 1'b0;
            toggled        <= 1'b0;
            toggledDelayed <= 1'b0;
            dataSampled    <= 1'b0;
            dataDelayed    <= 1'b0;
        end else begin
            prevControl    <= control;
            toggled        <= control ^ prevControl; // One bit per control edge
            toggledDelayed <= toggled;
            dataSampled    <= data;
            dataDelayed    <= dataSampled;
        end
    end

    // Bits arrive LSB first, so each one enters at the top and walks down
    always_ff @(posedge clk) begin
        if (rst) begin
            receivedTop <= '0;
        end else if (toggledDelayed) begin
            receivedTop <= {dataDelayed, receivedTop[TOP_WIDTH-1:1]};
        end
    end

endmodule

`default_nettype wire

// File: source/topBroadcast.sv
`timescale 1ns/1ps
`default_nettype none

module topBroadcast #(
    parameter int WARMUP_CYCLES = 15,
    parameter int DONE_DELAY    = 12,
    parameter int NUM_RECEIVERS = 2
) (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic [topBroadcastPkg::TOP_WIDTH-1:0]               topIn,
    input  logic                                              topInValid,
    input  logic                                              pipelineIsEmpty,
    output logic                                              stallInput,
    output logic [topBroadcastPkg::CHANNEL_WIDTH-1:0]           topChannel,
    output logic [NUM_RECEIVERS*topBroadcastPkg::TOP_WIDTH-1:0] receivedTops
);

    import topBroadcastPkg::*;

    logic                 restart;
    logic                 warmingUp;
    logic                 transmitTop;
    logic                 doneTransmitting;
    logic [TOP_WIDTH-1:0] pendingTop;

    warmupTimer #(
        .WARMUP_CYCLES(WARMUP_CYCLES)
    ) timer (
        .clk      (clk),
        .rst      (rst),
        .restart  (restart),
        .warmingUp(warmingUp)
    );

    topManager manager (
        .clk             (clk),
        .rst             (rst),
        .topIn           (topIn),
        .topInValid      (topInValid),
        .pipelineIsEmpty (pipelineIsEmpty),
        .warmingUp       (warmingUp),
        .doneTransmitting(doneTransmitting),
        .stallInput      (stallInput),
        .restart         (restart),
        .transmitTop     (transmitTop),
        .pendingTop      (pendingTop)
    );

    topTransmitter #(
        .DONE_DELAY(DONE_DELAY)
    ) transmitter (
        .clk             (clk),
        .rst             (rst),
        .pendingTop      (pendingTop),
        .transmitTop     (transmitTop),
        .doneTransmitting(doneTransmitting),
        .topChannel      (topChannel)
    );

    // Every receiver listens to the same channel, receiver 0 lands in the low bits
    for (genvar i = 0; i < NUM_RECEIVERS; i++) begin : receiverGen
        topReceiver receiver (
            .clk        (clk),
            .rst        (rst),
            .topChannel (topChannel),
            .receivedTop(receivedTops[i*TOP_WIDTH +: TOP_WIDTH])
        );
    end

endmodule

`default_nettype wire

// File: dv/topModel.svh
`ifndef TOP_MODEL_SVH
`define TOP_MODEL_SVH

// Reference model of the broadcast as seen by the receivers

// Each receiver sees one control transition per bit of the final transmission
localparam int EXPECTED_TOGGLES = TOP_WIDTH;

// The last top that the stimulus offered while the DUT was idle
logic [TOP_WIDTH-1:0] acceptedTop = '0;

task automatic recordAcceptedTop(input logic [TOP_WIDTH-1:0] top);
    acceptedTop = top;
endtask

// Every receiver rebuilds the same word with receiver 0 in the low bits
function automatic logic [ALL_WIDTH-1:0] expectedReceivedTops();
    logic [ALL_WIDTH-1:0] expected;
    expected = '0;
    for (int i = 0; i < NUM_RECEIVERS; i++) begin
        expected[i*TOP_WIDTH +: TOP_WIDTH] = acceptedTop;
    end
    return expected;
endfunction

// The restart pulse holds off cycle 1 after the strobe
// The timer then runs for WARMUP_CYCLES more cycles
function automatic logic warmupRunning(input int cyclesSinceStrobe);
    logic running;
    running = (cyclesSinceStrobe >= 1) && (cyclesSinceStrobe <= WARMUP_CYCLES + 1);
    return running;
endfunction

`endif

// File: dv/topBroadcastTb.sv
`timescale 1ns/1ps
`default_nettype none

module topBroadcastTb;

    import topBroadcastPkg::*;

    localparam int WARMUP_CYCLES = 15;
    localparam int DONE_DELAY    = 12;
    localparam int NUM_RECEIVERS = 2;
    localparam int ALL_WIDTH     = NUM_RECEIVERS * TOP_WIDTH;
    localparam int NUM_TOPS      = 20;
    localparam int MAX_CYCLES    = NUM_TOPS * 400; // Worst-case transfer per top
    localparam int SETTLE_CYCLES = 20;

    logic                     clk = 1'b0;
    logic                     rst;
    logic [TOP_WIDTH-1:0]     topIn;
    logic                     topInValid;
    logic                     pipelineIsEmpty;
    logic                     stallInput;
    logic [CHANNEL_WIDTH-1:0] topChannel;
    logic [ALL_WIDTH-1:0]     receivedTops;

    `include "topModel.svh"

    integer               seed = 32'h9a09;
    int                   cycleCount = 0;
    int                   topsDone = 0;
    int                   sinceStrobe = 0;
    int                   toggleCount = 0;
    logic                 modelPending = 1'b0; // Manager still restarting the transmitter
    logic                 resetChecked = 1'b0;
    logic                 prevStall = 1'b0;
    logic [CHANNEL_WIDTH-1:0] prevChannel = '0;
    logic [ALL_WIDTH-1:0] prevReceived = '0;

    topBroadcast #(
        .WARMUP_CYCLES(WARMUP_CYCLES),
        .DONE_DELAY   (DONE_DELAY),
        .NUM_RECEIVERS(NUM_RECEIVERS)
    ) dut (
        .clk            (clk),
        .rst            (rst),
        .topIn          (topIn),
        .topInValid     (topInValid),
        .pipelineIsEmpty(pipelineIsEmpty),
        .stallInput     (stallInput),
        .topChannel     (topChannel),
        .receivedTops   (receivedTops)
    );

    always #50 clk = ~clk;

    task automatic reportMismatch(input string signalName, input logic [ALL_WIDTH-1:0] actual,
                                  input logic [ALL_WIDTH-1:0] expected);
        $display("ERR %s: got %h, expected %h", signalName, actual, expected);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            reportFailure("timeout: the broadcasts did not finish within the cycle limit");
        end
    end

    initial begin
        logic [TOP_WIDTH-1:0] newTop;
        int                   gap;
        int                   holdLow;
        rst             = 1'b1;
        topIn           = '0;
        topInValid      = 1'b0;
        pipelineIsEmpty = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < NUM_TOPS; n++) begin
            @(negedge clk);
            while (stallInput) @(negedge clk); // A new top only goes out while idle
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge clk);
            newTop  = {$random(seed), $random(seed), $random(seed), $random(seed)};
            holdLow = $unsigned($random(seed)) % 41;
            @(posedge clk);
            topIn      <= newTop;
            topInValid <= 1'b1;
            recordAcceptedTop(newTop);
            @(posedge clk);
            topInValid <= 1'b0;
            repeat (holdLow) begin
                pipelineIsEmpty <= 1'b0;
                @(posedge clk);
            end
            // Random busy cycles until the model sees the final start
            while (modelPending) begin
                pipelineIsEmpty <= ($unsigned($random(seed)) % 4) != 0;
                @(posedge clk);
            end
            pipelineIsEmpty <= 1'b1;
        end
        while (topsDone < NUM_TOPS) @(posedge clk);
        repeat (SETTLE_CYCLES) @(negedge clk);
        if (!stallInput && receivedTops == expectedReceivedTops()) begin
            $display("all tests passed");
            $finish;
        end else begin
            reportFailure("the DUT is not idle with the last top at the end of the run");
        end
    end

    // Outputs are sampled on the falling edge, where they are stable
    always @(negedge clk) begin
        if (rst) begin
            resetChecked = 1'b0;
            modelPending = 1'b0;
            toggleCount  = 0;
        end else begin
            if (!resetChecked) begin
                assert (stallInput == 1'b0)
                    else reportMismatch("stallInput", ALL_WIDTH'(stallInput), '0);
                assert (topChannel == '0)
                    else reportMismatch("topChannel", ALL_WIDTH'(topChannel), '0);
                assert (receivedTops == '0)
                    else reportMismatch("receivedTops", receivedTops, '0);
                resetChecked = 1'b1;
            end else if (!stallInput && !prevStall) begin
                assert (topChannel == prevChannel)
                    else reportMismatch("topChannel", ALL_WIDTH'(topChannel),
                                        ALL_WIDTH'(prevChannel));
                assert (receivedTops == prevReceived)
                    else reportMismatch("receivedTops", receivedTops, prevReceived);
            end

            if (topInValid) begin
                sinceStrobe  = 0;
                modelPending = 1'b1;
                toggleCount  = 0;
            end else if (sinceStrobe < MAX_CYCLES) begin
                sinceStrobe = sinceStrobe + 1;
            end

            if (!pipelineIsEmpty) begin
                assert (stallInput)
                    else reportFailure("stallInput is low while the pipeline is still busy");
            end

            if (modelPending && !topInValid) begin
                assert (stallInput)
                    else reportFailure("stallInput is low while the manager holds a top");
                if (!pipelineIsEmpty || warmupRunning(sinceStrobe)) begin
                    toggleCount = 0; // Any earlier start is overridden
                end else begin
                    modelPending = 1'b0; // The final transmission starts after this cycle
                end
            end else if (stallInput && topChannel[0] != prevChannel[0]) begin
                toggleCount = toggleCount + 1;
            end

            if (prevStall && !stallInput) begin
                assert (!modelPending)
                    else reportFailure("stallInput fell before the final transmission began");
                assert (receivedTops == expectedReceivedTops())
                    else reportMismatch("receivedTops", receivedTops, expectedReceivedTops());
                assert (toggleCount == EXPECTED_TOGGLES)
                    else reportMismatch("control toggles", ALL_WIDTH'(toggleCount),
                                        ALL_WIDTH'(EXPECTED_TOGGLES));
                topsDone = topsDone + 1;
            end
        end
        prevStall    = stallInput;
        prevChannel  = topChannel;
        prevReceived = receivedTops;
    end

endmodule

`default_nettype wire

// File: topBroadcast.f
+incdir+dv
source/topBroadcastPkg.sv
source/warmupTimer.sv
source/topManager.sv
source/topTransmitter.sv
source/topReceiver.sv
source/topBroadcast.sv
dv/topBroadcastTb.sv

// File: Makefile
SIM       ?= verilator
TOP       ?= topBroadcastTb
FILELIST  ?= topBroadcast.f
BUILD_DIR ?= obj_dir
SIM_FLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with $(SIM) and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The simulator exits with a failing status when the testbench stops on $$fatal
test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
